// ==== logic/cfg_params.svh ====
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// Host bus widths
`define CFG_IF_W         32
`define CFG_ADR_W        32

// Block select, address bits above 11 must match the base
`define CFG_BLK_MASK     32'hFFFF_F000
`define CFG_BLK_BASE     32'h4000_0000

// Regions in address bits 11:8
`define CFG_REGION_CTRL  4'h0
`define CFG_REGION_CON   4'h1
`define CFG_SUB_W        8        // Sub-address, word index in 7:2

// Control region sub-addresses
`define CFG_ADDR_CTRL    8'h00
`define CFG_ADDR_GIEN    8'h04
`define CFG_ADDR_IEN     8'h08
`define CFG_ADDR_ISTAT   8'h0C
`define CFG_ADDR_STATUS  8'h10
`define CFG_ADDR_CYCLES  8'h14
`define CFG_ADDR_STALLS  8'h18

// Configuration fields
`define CFG_CON_WORDS    3        // 69 bits packed over three words
`define CFG_IDX_W        15
`define CFG_TH_W         2
`define CFG_RES_MASK_W   12
`define CFG_APPR_MASK_W  8
`define CFG_STAT_CODE_W  5
`define CFG_SRAM_N       3        // Double-buffered SRAM groups A, B, C

// Control word bit positions
`define CFG_BIT_START    0
`define CFG_BIT_DONE     1
`define CFG_BIT_IDLE     2
`define CFG_BIT_READY    3
`define CFG_BIT_MEMSW    16
`define CFG_BIT_KEEP_A   17       // Keep A, B, C in 17..19
`define CFG_BIT_SRST     23

`define CFG_CTRL_TAG     8'hAC
`define CFG_BAD_ADDR     32'h2BADADD2

`endif

// ==== logic/cfg_pkg.sv ====
package cfg_pkg;

    // Decoded register select
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_CTRL,
        SEL_GIEN,
        SEL_IEN,
        SEL_ISTAT,
        SEL_STATUS,
        SEL_CYCLES,
        SEL_STALLS,
        SEL_CON
    } reg_sel_e;

    // Stimulus table operations
    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_DONE_LEVEL,      // Drive the engine done level
        OP_STALL,           // Drop pipeline / pop enables
        OP_IDLE
    } host_op_e;

endpackage

// ==== logic/cfg_addr_decode.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_addr_decode import cfg_pkg::*; (
    input  logic [`CFG_ADR_W-1:0] i_address,
    input  logic                  i_wren,
    input  logic                  i_rden,
    output logic                  o_wr_en,
    output logic                  o_rd_en,
    output reg_sel_e              o_sel,
    output logic [1:0]            o_con_idx
);

    logic                  in_blk;      // Address inside this block
    logic [3:0]            region;
    logic [`CFG_SUB_W-1:0] sub;

    assign in_blk    = (i_address & `CFG_BLK_MASK) == `CFG_BLK_BASE;
    assign region    = i_address[`CFG_SUB_W+3:`CFG_SUB_W];
    assign sub       = i_address[`CFG_SUB_W-1:0];
    assign o_con_idx = sub[3:2];         // Upper index bits checked below

    always_comb begin
        o_sel = SEL_NONE;
        if (in_blk && region == `CFG_REGION_CTRL) begin
            case (sub)
                `CFG_ADDR_CTRL:   o_sel = SEL_CTRL;
                `CFG_ADDR_GIEN:   o_sel = SEL_GIEN;
                `CFG_ADDR_IEN:    o_sel = SEL_IEN;
                `CFG_ADDR_ISTAT:  o_sel = SEL_ISTAT;
                `CFG_ADDR_STATUS: o_sel = SEL_STATUS;
                `CFG_ADDR_CYCLES: o_sel = SEL_CYCLES;
                `CFG_ADDR_STALLS: o_sel = SEL_STALLS;
                default:          o_sel = SEL_NONE;
            endcase
        end else if (in_blk && region == `CFG_REGION_CON && sub[1:0] == 2'b00
                     && sub[7:2] < `CFG_CON_WORDS) begin
            o_sel = SEL_CON;
        end
    end

    assign o_wr_en = i_wren && (o_sel != SEL_NONE);   // Unmapped writes dropped
    assign o_rd_en = i_rden;                          // Unmapped reads answer bad-address

endmodule

// ==== logic/cfg_ctrl_regs.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_ctrl_regs import cfg_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_wr_en,
    input  reg_sel_e                    i_sel,
    input  logic [`CFG_IF_W-1:0]        i_wdata,
    input  logic [`CFG_IF_W-1:0]        i_wmask,
    input  logic                        i_done,           // Engine done level
    input  logic                        i_act_deadlock,
    input  logic                        i_wei_deadlock,
    input  logic                        i_feed_deadlock,
    input  logic [`CFG_STAT_CODE_W-1:0] i_ctx_status,
    input  logic [`CFG_STAT_CODE_W-1:0] i_feed_status,
    input  logic [`CFG_STAT_CODE_W-1:0] i_out_status,
    output logic                        o_start,
    output logic                        o_soft_reset,
    output logic [`CFG_SRAM_N-1:0]      o_sram_select,    // Bit 0 is group A
    output logic                        o_doneintr,
    output logic                        o_start_acc,
    output logic                        o_run_end,
    output logic [`CFG_IF_W-1:0]        o_ctrl_word,
    output logic [`CFG_IF_W-1:0]        o_gien_word,
    output logic [`CFG_IF_W-1:0]        o_ien_word,
    output logic [`CFG_IF_W-1:0]        o_istat_word,
    output logic [`CFG_IF_W-1:0]        o_status_word
);

    localparam int STAT_BITS = 3 + 3 * `CFG_STAT_CODE_W;

    logic start_q, start_prv_q;          // Self-clearing start and its delay
    logic memsw_q, memsw_prv_q;
    logic srst_q, srst_prv_q;
    logic done_q, idle_q, ready_q;
    logic gien_q, ien_q, istat_q;
    logic [`CFG_SRAM_N-1:0] keep_q;
    logic [`CFG_SRAM_N-1:0] keep_msk;
    logic wr_ctrl, wr_gien, wr_ien, wr_istat;
    logic memsw_edge;

    assign wr_ctrl  = i_wr_en && (i_sel == SEL_CTRL);
    assign wr_gien  = i_wr_en && (i_sel == SEL_GIEN);
    assign wr_ien   = i_wr_en && (i_sel == SEL_IEN);
    assign wr_istat = i_wr_en && (i_sel == SEL_ISTAT);
    assign keep_msk = i_wmask[`CFG_BIT_KEEP_A +: `CFG_SRAM_N];

    // *************************************************************************
    // Register file
    // *************************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            start_q       <= 1'b0;
            start_prv_q   <= 1'b0;
            memsw_q       <= 1'b0;
            memsw_prv_q   <= 1'b0;
            srst_q        <= 1'b0;
            srst_prv_q    <= 1'b0;
            done_q        <= 1'b0;
            idle_q        <= 1'b1;            // Engine idle out of reset
            ready_q       <= 1'b1;
            gien_q        <= 1'b0;
            ien_q         <= 1'b0;
            istat_q       <= 1'b0;
            keep_q        <= '0;
            o_sram_select <= '0;
            o_status_word <= '0;
        end else begin
            // Pulse bits drop back unless written again
            start_q     <= wr_ctrl & i_wmask[`CFG_BIT_START] & i_wdata[`CFG_BIT_START];
            memsw_q     <= wr_ctrl & i_wmask[`CFG_BIT_MEMSW] & i_wdata[`CFG_BIT_MEMSW];
            srst_q      <= wr_ctrl & i_wmask[`CFG_BIT_SRST] & i_wdata[`CFG_BIT_SRST];
            start_prv_q <= start_q;
            memsw_prv_q <= memsw_q;
            srst_prv_q  <= srst_q;
            idle_q      <= i_done;             // Idle and ready mirror done
            ready_q     <= i_done;
            if (wr_ctrl)
                keep_q <= (keep_q & ~keep_msk)
                          | (i_wdata[`CFG_BIT_KEEP_A +: `CFG_SRAM_N] & keep_msk);
            if (wr_gien && i_wmask[0]) gien_q <= i_wdata[0];
            if (wr_ien && i_wmask[0])  ien_q  <= i_wdata[0];
            // Set from the engine wins over a clear-on-write-one
            if (o_run_end)
                done_q <= 1'b1;
            else if (wr_ctrl && i_wmask[`CFG_BIT_DONE] && i_wdata[`CFG_BIT_DONE])
                done_q <= 1'b0;
            if (o_run_end)
                istat_q <= 1'b1;
            else if (wr_istat && i_wmask[0] && i_wdata[0])
                istat_q <= 1'b0;
            // Toggle unkept groups on accepted start or switch
            if (o_start_acc || memsw_edge)
                o_sram_select <= o_sram_select ^ ~keep_q;
            o_status_word <= {{(`CFG_IF_W-STAT_BITS){1'b0}}, i_out_status, i_feed_status,
                              i_ctx_status, i_feed_deadlock, i_wei_deadlock, i_act_deadlock};
        end
    end

    // Edge detects
    assign o_start      = start_q & ~start_prv_q;
    assign o_start_acc  = o_start & ready_q;        // Engine must be ready
    assign memsw_edge   = memsw_q & ~memsw_prv_q;
    assign o_soft_reset = srst_q & ~srst_prv_q;
    assign o_run_end    = i_done & ~idle_q;         // First edge with done high
    assign o_doneintr   = istat_q & gien_q & ien_q;

    // *************************************************************************
    // Read words
    // *************************************************************************
    always_comb begin
        o_ctrl_word = '0;
        o_ctrl_word[`CFG_BIT_START] = start_q;
        o_ctrl_word[`CFG_BIT_DONE]  = done_q;
        o_ctrl_word[`CFG_BIT_IDLE]  = idle_q;
        o_ctrl_word[`CFG_BIT_READY] = ready_q;
        o_ctrl_word[`CFG_BIT_MEMSW] = memsw_q;
        o_ctrl_word[`CFG_BIT_KEEP_A +: `CFG_SRAM_N] = keep_q;
        o_ctrl_word[`CFG_BIT_SRST]  = srst_q;
        o_ctrl_word[`CFG_IF_W-1 -: 8] = `CFG_CTRL_TAG;
    end

    assign o_gien_word  = {{(`CFG_IF_W-1){1'b0}}, gien_q};
    assign o_ien_word   = {{(`CFG_IF_W-1){1'b0}}, ien_q};
    assign o_istat_word = {{(`CFG_IF_W-1){1'b0}}, istat_q};

endmodule

// ==== logic/cfg_perf_counters.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_perf_counters (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_start_acc,     // Clears and arms both counters
    input  logic                 i_run_end,       // Stops counting, values hold
    input  logic                 i_pipeline_en,
    input  logic                 i_pop_en,
    output logic [`CFG_IF_W-1:0] o_cycles,
    output logic [`CFG_IF_W-1:0] o_stalls
);

    localparam logic [`CFG_IF_W-1:0] CNT_ONE = 1;

    logic cnt_en_q;                      // Run in progress

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            cnt_en_q <= 1'b0;
            o_cycles <= '0;
            o_stalls <= '0;
        end else if (i_start_acc) begin
            cnt_en_q <= 1'b1;
            o_cycles <= '0;
            o_stalls <= '0;
        end else begin
            if (i_run_end)
                cnt_en_q <= 1'b0;
            if (cnt_en_q) begin
                o_cycles <= o_cycles + CNT_ONE;
                // Hard stall on pipeline, soft stall on pop
                if (!i_pipeline_en || !i_pop_en)
                    o_stalls <= o_stalls + CNT_ONE;
            end
        end
    end

endmodule

// ==== logic/cfg_shadow_regs.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_shadow_regs import cfg_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_wr_en,
    input  reg_sel_e                    i_sel,
    input  logic [1:0]                  i_con_idx,
    input  logic [`CFG_IF_W-1:0]        i_wdata,
    input  logic [`CFG_IF_W-1:0]        i_wmask,
    input  logic                        i_start_acc,      // Shadow copy strobe
    output logic [`CFG_IF_W-1:0]        o_con_rdword,     // Staging word for reads
    output logic [`CFG_IDX_W-1:0]       o_incntlim,
    output logic [`CFG_IDX_W-1:0]       o_act_reps,
    output logic [`CFG_IDX_W-1:0]       o_wei_reps,
    output logic [`CFG_TH_W-1:0]        o_thres,
    output logic [`CFG_RES_MASK_W-1:0]  o_mult_res_mask,
    output logic [`CFG_APPR_MASK_W-1:0] o_mult_appr_mask,
    output logic                        o_sram_deepsleep,
    output logic                        o_sram_powergate
);

    // Field offsets, packed from bit 0 across the three words
    localparam int CON_W    = `CFG_CON_WORDS * `CFG_IF_W;
    localparam int OFS_TH   = 3 * `CFG_IDX_W;
    localparam int OFS_RES  = OFS_TH + `CFG_TH_W;
    localparam int OFS_APPR = OFS_RES + `CFG_RES_MASK_W;
    localparam int OFS_DS   = OFS_APPR + `CFG_APPR_MASK_W;

    logic [`CFG_IF_W-1:0] stage_q  [`CFG_CON_WORDS];   // Host-visible
    logic [`CFG_IF_W-1:0] shadow_q [`CFG_CON_WORDS];   // Seen by the engine
    logic [CON_W-1:0]     flat;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int w = 0; w < `CFG_CON_WORDS; w++) begin
                stage_q[w]  <= '0;
                shadow_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `CFG_CON_WORDS; w++) begin
                if (i_wr_en && i_sel == SEL_CON && i_con_idx == 2'(w))
                    stage_q[w] <= (stage_q[w] & ~i_wmask) | (i_wdata & i_wmask);
                if (i_start_acc)
                    shadow_q[w] <= stage_q[w];   // Old staging value on a same-edge write
            end
        end
    end

    always_comb begin
        o_con_rdword = '0;
        for (int w = 0; w < `CFG_CON_WORDS; w++) begin
            if (i_con_idx == 2'(w)) o_con_rdword = stage_q[w];
            flat[w*`CFG_IF_W +: `CFG_IF_W] = shadow_q[w];
        end
    end

    // Unpack
    assign o_incntlim       = flat[0 +: `CFG_IDX_W];
    assign o_act_reps       = flat[`CFG_IDX_W +: `CFG_IDX_W];
    assign o_wei_reps       = flat[2*`CFG_IDX_W +: `CFG_IDX_W];
    assign o_thres          = flat[OFS_TH +: `CFG_TH_W];
    assign o_mult_res_mask  = flat[OFS_RES +: `CFG_RES_MASK_W];
    assign o_mult_appr_mask = flat[OFS_APPR +: `CFG_APPR_MASK_W];
    assign o_sram_deepsleep = flat[OFS_DS];
    assign o_sram_powergate = flat[OFS_DS+1];

endmodule

// ==== logic/cfg_read_mux.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_read_mux import cfg_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_rd_en,
    input  reg_sel_e             i_sel,
    input  logic [`CFG_IF_W-1:0] i_ctrl_word,
    input  logic [`CFG_IF_W-1:0] i_gien_word,
    input  logic [`CFG_IF_W-1:0] i_ien_word,
    input  logic [`CFG_IF_W-1:0] i_istat_word,
    input  logic [`CFG_IF_W-1:0] i_status_word,
    input  logic [`CFG_IF_W-1:0] i_cycles,
    input  logic [`CFG_IF_W-1:0] i_stalls,
    input  logic [`CFG_IF_W-1:0] i_con_word,
    output logic [`CFG_IF_W-1:0] o_rdata        // Held between reads
);

    logic [`CFG_IF_W-1:0] rd_word;

    always_comb begin
        case (i_sel)
            SEL_CTRL:   rd_word = i_ctrl_word;
            SEL_GIEN:   rd_word = i_gien_word;
            SEL_IEN:    rd_word = i_ien_word;
            SEL_ISTAT:  rd_word = i_istat_word;
            SEL_STATUS: rd_word = i_status_word;
            SEL_CYCLES: rd_word = i_cycles;
            SEL_STALLS: rd_word = i_stalls;
            SEL_CON:    rd_word = i_con_word;
            default:    rd_word = `CFG_BAD_ADDR;   // Unmapped or out of block
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn)
            o_rdata <= '0;
        else if (i_rd_en)
            o_rdata <= rd_word;
    end

    // Every register word feeding the mux is defined once out of reset
    a_rdata_known: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !$isunknown(o_rdata));

endmodule

// ==== logic/cfg_regs_top.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module cfg_regs_top import cfg_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    // Host side
    input  logic [`CFG_ADR_W-1:0]       i_address,
    input  logic                        i_wren,
    input  logic                        i_rden,
    input  logic [`CFG_IF_W-1:0]        i_wdata,
    input  logic [`CFG_IF_W-1:0]        i_wmask,
    output logic [`CFG_IF_W-1:0]        o_rdata,
    // Engine status
    input  logic                        i_done,
    input  logic                        i_act_deadlock,
    input  logic                        i_wei_deadlock,
    input  logic                        i_feed_deadlock,
    input  logic [`CFG_STAT_CODE_W-1:0] i_ctx_status,
    input  logic [`CFG_STAT_CODE_W-1:0] i_feed_status,
    input  logic [`CFG_STAT_CODE_W-1:0] i_out_status,
    input  logic                        i_pipeline_en,
    input  logic                        i_pop_en,
    // Engine control
    output logic                        o_start,
    output logic                        o_soft_reset,
    output logic                        o_doneintr,
    output logic [`CFG_SRAM_N-1:0]      o_sram_select,
    output logic                        o_sram_deepsleep,
    output logic                        o_sram_powergate,
    output logic [`CFG_IDX_W-1:0]       o_incntlim,
    output logic [`CFG_IDX_W-1:0]       o_act_reps,
    output logic [`CFG_IDX_W-1:0]       o_wei_reps,
    output logic [`CFG_TH_W-1:0]        o_thres,
    output logic [`CFG_RES_MASK_W-1:0]  o_mult_res_mask,
    output logic [`CFG_APPR_MASK_W-1:0] o_mult_appr_mask
);

    logic                 wr_en, rd_en;
    reg_sel_e             sel;
    logic [1:0]           con_idx;
    logic                 start_acc, run_end;        // Run boundaries
    logic [`CFG_IF_W-1:0] ctrl_word, gien_word, ien_word, istat_word;
    logic [`CFG_IF_W-1:0] status_word, cycles, stalls, con_word;

    cfg_addr_decode u_decode (
        .i_address(i_address), .i_wren(i_wren), .i_rden(i_rden),
        .o_wr_en(wr_en), .o_rd_en(rd_en), .o_sel(sel), .o_con_idx(con_idx));

    cfg_ctrl_regs u_ctrl (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_wr_en(wr_en), .i_sel(sel),
        .i_wdata(i_wdata), .i_wmask(i_wmask), .i_done(i_done),
        .i_act_deadlock(i_act_deadlock), .i_wei_deadlock(i_wei_deadlock),
        .i_feed_deadlock(i_feed_deadlock), .i_ctx_status(i_ctx_status),
        .i_feed_status(i_feed_status), .i_out_status(i_out_status),
        .o_start(o_start), .o_soft_reset(o_soft_reset), .o_sram_select(o_sram_select),
        .o_doneintr(o_doneintr), .o_start_acc(start_acc), .o_run_end(run_end),
        .o_ctrl_word(ctrl_word), .o_gien_word(gien_word), .o_ien_word(ien_word),
        .o_istat_word(istat_word), .o_status_word(status_word));

    cfg_perf_counters u_counters (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_start_acc(start_acc), .i_run_end(run_end),
        .i_pipeline_en(i_pipeline_en), .i_pop_en(i_pop_en),
        .o_cycles(cycles), .o_stalls(stalls));

    cfg_shadow_regs u_shadow (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_wr_en(wr_en), .i_sel(sel),
        .i_con_idx(con_idx), .i_wdata(i_wdata), .i_wmask(i_wmask),
        .i_start_acc(start_acc), .o_con_rdword(con_word),
        .o_incntlim(o_incntlim), .o_act_reps(o_act_reps), .o_wei_reps(o_wei_reps),
        .o_thres(o_thres), .o_mult_res_mask(o_mult_res_mask),
        .o_mult_appr_mask(o_mult_appr_mask), .o_sram_deepsleep(o_sram_deepsleep),
        .o_sram_powergate(o_sram_powergate));

    cfg_read_mux u_rdmux (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_rd_en(rd_en), .i_sel(sel),
        .i_ctrl_word(ctrl_word), .i_gien_word(gien_word), .i_ien_word(ien_word),
        .i_istat_word(istat_word), .i_status_word(status_word), .i_cycles(cycles),
        .i_stalls(stalls), .i_con_word(con_word), .o_rdata(o_rdata));

endmodule

// ==== tb/cfg_checker.sv ====
`timescale 1ns/100ps

module cfg_checker (
    input  logic        i_clk,
    input  logic        i_rstn,
    input  logic        i_rden,        // Host read strobe as driven
    input  logic [31:0] i_rdata,
    input  logic [31:0] i_exp_rdata,
    input  logic        i_chk_en,      // Compare engine-side outputs this cycle
    input  logic [72:0] i_fld,         // {doneintr, sram_select, 69 field bits}
    input  logic [72:0] i_exp_fld,
    input  logic        i_start,
    input  logic        i_soft_reset,
    output int          o_errors,
    output int          o_start_cnt,
    output int          o_srst_cnt
);

    logic        rd_pend;              // Read sampled at the last edge
    logic [31:0] rd_exp;
    logic        start_prev;

    initial begin
        o_errors    = 0;
        o_start_cnt = 0;
        o_srst_cnt  = 0;
        rd_pend     = 1'b0;
        start_prev  = 1'b0;
    end

    // Capture at the edge where the DUT samples the read
    always @(posedge i_clk) begin
        rd_pend <= i_rstn & i_rden;
        rd_exp  <= i_exp_rdata;
    end

    // *************************************************************************
    // Compare mid-cycle, outputs settled
    // *************************************************************************
    always @(negedge i_clk) begin
        if (i_rstn) begin
            if (rd_pend && i_rdata !== rd_exp) begin
                $display("ERROR o_rdata got %h expected %h", i_rdata, rd_exp);
                o_errors++;
            end
            if (i_chk_en && i_fld !== i_exp_fld) begin
                $display("ERROR fields got %h expected %h", i_fld, i_exp_fld);
                o_errors++;
            end
            if (i_start) begin
                o_start_cnt++;
                if (start_prev) begin
                    $display("Start pulse stayed high for two cycles");
                    o_errors++;
                end
            end
            start_prev = i_start;
            if (i_soft_reset) o_srst_cnt++;   // One per write expected
        end
    end

endmodule

// ==== tb/tb_cfg_regs.sv ====
`timescale 1ns/100ps
`include "cfg_params.svh"

module tb_cfg_regs import cfg_pkg::*; ();

    localparam logic [31:0] BASE  = `CFG_BLK_BASE;
    localparam logic [31:0] A_CTL = BASE | 32'(`CFG_ADDR_CTRL);
    localparam logic [31:0] A_GIE = BASE | 32'(`CFG_ADDR_GIEN);
    localparam logic [31:0] A_IEN = BASE | 32'(`CFG_ADDR_IEN);
    localparam logic [31:0] A_IST = BASE | 32'(`CFG_ADDR_ISTAT);
    localparam logic [31:0] A_STS = BASE | 32'(`CFG_ADDR_STATUS);
    localparam logic [31:0] A_CYC = BASE | 32'(`CFG_ADDR_CYCLES);
    localparam logic [31:0] A_STL = BASE | 32'(`CFG_ADDR_STALLS);
    localparam logic [31:0] A_CON = BASE | 32'h100;   // Config region, word 0
    localparam logic [31:0] BAD   = `CFG_BAD_ADDR;

    logic i_clk = 1'b0;
    logic i_rstn, i_wren, i_rden, i_done, i_pipeline_en, i_pop_en;
    logic i_act_deadlock, i_wei_deadlock, i_feed_deadlock;
    logic [4:0] i_ctx_status, i_feed_status, i_out_status;
    logic [31:0] i_address, i_wdata, i_wmask, o_rdata, exp_rdata;
    logic o_start, o_soft_reset, o_doneintr, o_sram_deepsleep, o_sram_powergate;
    logic [2:0] o_sram_select;
    logic [14:0] o_incntlim, o_act_reps, o_wei_reps;
    logic [1:0] o_thres;
    logic [11:0] o_mult_res_mask;
    logic [7:0] o_mult_appr_mask;
    logic chk_en;
    logic [72:0] exp_fld;
    int errors, start_cnt, srst_cnt;

    // Stimulus table, one column per queue
    host_op_e t_op[$];
    logic [31:0] t_addr[$], t_data[$], t_mask[$], t_exp[$];
    int t_reps[$];
    logic t_chk[$];
    logic [72:0] t_fld[$];

    // Expected engine-side state
    logic [31:0] m_stage[3];
    logic [95:0] m_shadow;
    logic [2:0] m_sram, m_keep;
    logic m_intr;
    integer seed = 32'hb2d16a63;
    int total, cyc, limit;

    always #4 i_clk = ~i_clk;

    cfg_regs_top u_dut (.*);

    cfg_checker u_chk (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_rden(i_rden), .i_rdata(o_rdata),
        .i_exp_rdata(exp_rdata), .i_chk_en(chk_en), .i_exp_fld(exp_fld),
        .i_fld({o_doneintr, o_sram_select, o_sram_powergate, o_sram_deepsleep,
                o_mult_appr_mask, o_mult_res_mask, o_thres, o_wei_reps, o_act_reps,
                o_incntlim}),
        .i_start(o_start), .i_soft_reset(o_soft_reset), .o_errors(errors),
        .o_start_cnt(start_cnt), .o_srst_cnt(srst_cnt));

    task automatic push(input host_op_e op, input logic [31:0] a, input logic [31:0] d,
                        input logic [31:0] m, input logic [31:0] e, input int r,
                        input logic c);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_mask.push_back(m);
        t_exp.push_back(e);
        t_reps.push_back(r);
        t_chk.push_back(c);
        t_fld.push_back({m_intr, m_sram, m_shadow[68:0]});   // Model snapshot
        total += r;
    endtask

    // Let pulses land, then compare outputs for two cycles
    task automatic settle_check();
        push(OP_IDLE, 0, 0, 0, 0, 2, 1'b0);
        push(OP_IDLE, 0, 0, 0, 0, 2, 1'b1);
    endtask

    task automatic con_write(input int w);
        logic [31:0] d;
        logic [31:0] m;
        d = $random(seed);
        m = $random(seed);
        m_stage[w] = (m_stage[w] & ~m) | (d & m);           // Masked merge
        push(OP_WRITE, A_CON + 4 * w, d, m, 0, 1, 1'b0);
        push(OP_READ, A_CON + 4 * w, 0, 0, m_stage[w], 1, 1'b0);
    endtask

    // Start with ready set: shadow copy and unkept groups toggle
    task automatic accept_start();
        m_shadow = {m_stage[2], m_stage[1], m_stage[0]};
        m_sram   = m_sram ^ ~m_keep;
        push(OP_WRITE, A_CTL, 1, 1, 0, 1, 1'b0);
    endtask

    // *************************************************************************
    // Table build, reset, apply
    // *************************************************************************
    initial begin
        {i_rstn, i_wren, i_rden, chk_en} = 4'b0000;
        {i_done, i_pipeline_en, i_pop_en} = 3'b111;         // Engine idle after reset
        {i_act_deadlock, i_wei_deadlock, i_feed_deadlock} = 3'b110;
        i_ctx_status = 5'h15;
        i_feed_status = 5'h0A;
        i_out_status = 5'h1F;
        {i_address, i_wdata, i_wmask, exp_rdata} = '0;
        exp_fld = '0;
        m_stage = '{default: '0};
        {m_shadow, m_sram, m_keep, m_intr} = '0;
        total = 0;
        cyc = 0;
        limit = 0;
        // Reset values and unmapped reads
        push(OP_READ, A_CTL, 0, 0, 32'hAC00000C, 1, 1'b0);
        push(OP_READ, A_GIE, 0, 0, 0, 1, 1'b0);
        push(OP_READ, A_IEN, 0, 0, 0, 1, 1'b0);
        push(OP_READ, A_IST, 0, 0, 0, 1, 1'b0);
        push(OP_READ, 32'h5000_0000, 0, 0, BAD, 1, 1'b0);
        push(OP_READ, BASE | 32'h1C, 0, 0, BAD, 1, 1'b0);
        push(OP_READ, A_CON + 12, 0, 0, BAD, 1, 1'b0);  // Index 3
        push(OP_READ, A_STS, 0, 0, {14'd0, 5'h1F, 5'h0A, 5'h15, 3'b011}, 1, 1'b0);
        // Staging writes, start refused while busy
        for (int w = 0; w < 3; w++) begin
            con_write(w);
            con_write(w);
        end
        settle_check();
        push(OP_DONE_LEVEL, 0, 0, 0, 0, 2, 1'b0);
        push(OP_WRITE, A_CTL, 1, 1, 0, 2, 1'b0);          // Held two cycles, one pulse
        settle_check();
        // Done and interrupt
        push(OP_DONE_LEVEL, 0, 1, 0, 0, 2, 1'b0);
        push(OP_READ, A_CTL, 0, 0, 32'hAC00000E, 1, 1'b0);
        push(OP_READ, A_IST, 0, 0, 1, 1, 1'b0);
        push(OP_WRITE, A_GIE, 1, 1, 0, 1, 1'b0);
        settle_check();
        m_intr = 1'b1;                                      // Both enables now set
        push(OP_WRITE, A_IEN, 1, 1, 0, 1, 1'b0);
        settle_check();
        m_intr = 1'b0;
        push(OP_WRITE, A_IST, 1, 1, 0, 1, 1'b0);
        settle_check();
        push(OP_READ, A_IST, 0, 0, 0, 1, 1'b0);
        push(OP_WRITE, A_CTL, 2, 2, 0, 1, 1'b0);
        push(OP_READ, A_CTL, 0, 0, 32'hAC00000C, 1, 1'b0);
        // Run of K = 12 busy edges, 6 of them stalled
        accept_start();
        push(OP_IDLE, 0, 0, 0, 0, 1, 1'b0);
        push(OP_DONE_LEVEL, 0, 0, 0, 0, 3, 1'b0);
        push(OP_STALL, 0, 0, 0, 0, 4, 1'b0);
        push(OP_STALL, 0, 3, 0, 0, 2, 1'b0);
        push(OP_STALL, 0, 2, 0, 0, 2, 1'b0);              // Pipeline low only
        push(OP_STALL, 0, 3, 0, 0, 1, 1'b0);
        push(OP_DONE_LEVEL, 0, 1, 0, 0, 2, 1'b0);
        m_intr = 1'b1;
        push(OP_READ, A_CYC, 0, 0, 13, 1, 1'b0);
        push(OP_READ, A_STL, 0, 0, 6, 1, 1'b0);
        settle_check();
        // New staging word stays hidden until the next accepted start
        con_write(0);
        settle_check();
        m_keep = 3'b010;
        m_sram = m_sram ^ ~m_keep;
        push(OP_WRITE, A_CTL, 32'h0005_0000, 32'h000F_0000, 0, 1, 1'b0);
        settle_check();
        push(OP_READ, A_CTL, 0, 0, 32'hAC04000E, 1, 1'b0);
        accept_start();
        settle_check();
        push(OP_WRITE, A_CTL, 32'h0080_0000, 32'h0080_0000, 0, 1, 1'b0);  // Soft reset
        push(OP_IDLE, 0, 0, 0, 0, 3, 1'b0);
        limit = 2 * total + 100;

        repeat (16) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;
        @(posedge i_clk);
        #1;
        for (int i = 0; i < t_op.size(); i++) begin
            {i_wren, i_rden} = 2'b00;
            chk_en    = t_chk[i];
            exp_fld   = t_fld[i];
            exp_rdata = t_exp[i];
            i_address = t_addr[i];
            i_wdata   = t_data[i];
            i_wmask   = t_mask[i];
            case (t_op[i])
                OP_WRITE:      i_wren = 1'b1;
                OP_READ:       i_rden = 1'b1;
                OP_DONE_LEVEL: i_done = t_data[i][0];
                OP_STALL: begin
                    i_pipeline_en = t_data[i][0];
                    i_pop_en      = t_data[i][1];
                end
                default: ;
            endcase
            repeat (t_reps[i]) @(posedge i_clk);
            #1;
        end
        {i_wren, i_rden, chk_en} = 3'b000;
        repeat (2) @(posedge i_clk);
        $display("Errors %0d, start pulses %0d of 3, soft reset pulses %0d of 1",
                 errors, start_cnt, srst_cnt);
        if (errors == 0 && start_cnt == 3 && srst_cnt == 1)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Run limit from the table length
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("Timeout, run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/cfg_pkg.sv
logic/cfg_addr_decode.sv
logic/cfg_ctrl_regs.sv
logic/cfg_perf_counters.sv
logic/cfg_shadow_regs.sv
logic/cfg_read_mux.sv
logic/cfg_regs_top.sv
tb/cfg_checker.sv
tb/tb_cfg_regs.sv

// ==== Makefile ====
TOOL   ?= verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_cfg_regs
FLIST  := list.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
